//--- hdl/qos_pkg.sv
// ##########################################################################
// QoS admission package with sizes, field widths, class codes and queue entries
// ##########################################################################
package qos_pkg;

    localparam int MSHR_NUM      = 8;
    localparam int MSHR_IDX_W    = 3;
    localparam int HIGH_POOL_NUM = 2;
    localparam int LOW_POOL_NUM  = 4;
    localparam int POOL_CNT_W    = 3;
    localparam int QOS_HIGH_MIN  = 8;
    localparam int BANK_NUM      = 4;
    localparam int BANK_IDX_W    = 2;
    localparam int BANK_CNT_W    = 3;
    localparam int SRCID_W       = 7;
    localparam int TXNID_W       = 8;
    localparam int QOS_W         = 4;
    localparam int PCRDTYPE_W    = 4;
    localparam int ACKQ_DEPTH    = 4;
    localparam int GNTQ_DEPTH    = 4;

    // credit type and grant qos per class
    localparam logic [PCRDTYPE_W-1:0] PCRD_LOW     = 4'd1;
    localparam logic [PCRDTYPE_W-1:0] PCRD_HIGH    = 4'd2;
    localparam logic [QOS_W-1:0]      GNT_QOS_LOW  = 4'h0;
    localparam logic [QOS_W-1:0]      GNT_QOS_HIGH = 4'hf;

    typedef enum logic [1:0] {
        CLASS_NONE = 2'd0,
        CLASS_LOW  = 2'd1,
        CLASS_HIGH = 2'd2
    } qos_class_t;

    typedef struct packed {
        logic [SRCID_W-1:0]    srcid;
        logic [TXNID_W-1:0]    txnid;
        logic [QOS_W-1:0]      qos;
        logic [PCRDTYPE_W-1:0] pcrdtype;
    } ack_entry_t;

    typedef struct packed {
        logic [SRCID_W-1:0]    srcid;
        logic [QOS_W-1:0]      qos;
        logic [PCRDTYPE_W-1:0] pcrdtype;
    } grant_entry_t;

endpackage

//--- hdl/resp_fifo.sv
// ##########################################################################
// Response queue as a circular buffer with a type parameter for the entry
// ##########################################################################
`timescale 1ns/100ps

module resp_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  logic   pop,
    input  entry_t wr_data,
    output entry_t rd_data,
    output logic   empty,
    output logic   full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_ok;
    logic               rd_ok;

    // a push into a full queue only lands when a pop frees the slot
    assign wr_ok = push & (~full | pop);
    assign rd_ok = pop & ~empty;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (!wr_ok && rd_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- hdl/pool_admit.sv
// ##########################################################################
// QoS admission with class decode, high and low pool counters, admit or retry
// ##########################################################################
`timescale 1ns/100ps

module pool_admit
    import qos_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic [SRCID_W-1:0] req_srcid,
    input  logic [TXNID_W-1:0] req_txnid,
    input  logic [QOS_W-1:0]   req_qos,
    input  logic               req_allowretry,
    input  logic               retire_valid,
    input  qos_class_t         retire_class,
    input  logic               convert,
    output logic               alloc_en,
    output logic               is_static,
    output qos_class_t         use_class,
    output logic               retry,
    output logic               is_high,
    output ack_entry_t         ack_data
);

    logic [POOL_CNT_W-1:0] high_cnt_q;
    logic [POOL_CNT_W-1:0] low_cnt_q;
    logic                  req_dyn;
    logic                  use_high;
    logic                  use_low;
    logic                  high_dec;
    logic                  low_dec;

    assign is_high   = (req_qos >= QOS_HIGH_MIN);
    assign req_dyn   = req_valid & req_allowretry;
    assign is_static = req_valid & ~req_allowretry;

    // high overflows into the low pool
    assign use_high = req_dyn & is_high & (high_cnt_q < HIGH_POOL_NUM);
    assign use_low  = req_dyn & ~use_high & (low_cnt_q < LOW_POOL_NUM);

    assign alloc_en  = is_static | use_high | use_low;
    assign retry     = req_dyn & ~use_high & ~use_low;
    assign use_class = use_high ? CLASS_HIGH : (use_low ? CLASS_LOW : CLASS_NONE);

    assign ack_data = '{
        srcid:    req_srcid,
        txnid:    req_txnid,
        qos:      req_qos,
        pcrdtype: is_high ? PCRD_HIGH : PCRD_LOW
    };

    // a converted entry stays counted as a reserved credit
    assign high_dec = retire_valid & ~convert & (retire_class == CLASS_HIGH);
    assign low_dec  = retire_valid & ~convert & (retire_class == CLASS_LOW);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt_q <= '0;
            low_cnt_q  <= '0;
        end else begin
            if (use_high && !high_dec) begin
                high_cnt_q <= high_cnt_q + 1'b1;
            end else if (!use_high && high_dec) begin
                high_cnt_q <= high_cnt_q - 1'b1;
            end
            if (use_low && !low_dec) begin
                low_cnt_q <= low_cnt_q + 1'b1;
            end else if (!use_low && low_dec) begin
                low_cnt_q <= low_cnt_q - 1'b1;
            end
        end
    end

    a_pool_bound: assert property (@(posedge clk) disable iff (rst)
        (high_cnt_q <= HIGH_POOL_NUM) && (low_cnt_q <= LOW_POOL_NUM));

endmodule

//--- hdl/mshr_tracker.sv
// ##########################################################################
// MSHR entry valid, reserved and class state with the lowest free entry search
// ##########################################################################
`timescale 1ns/100ps

module mshr_tracker
    import qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_en,
    input  logic                  is_static,
    input  qos_class_t            use_class,
    input  logic                  retire_valid,
    input  logic [MSHR_IDX_W-1:0] retire_idx,
    input  logic                  convert,
    output logic [MSHR_IDX_W-1:0] alloc_idx,
    output qos_class_t            retire_class
);

    logic [MSHR_NUM-1:0] valid_q;
    logic [MSHR_NUM-1:0] resv_q;
    qos_class_t          class_q [MSHR_NUM];
    logic [MSHR_NUM-1:0] dyn_free;
    logic [MSHR_NUM-1:0] static_free;

    function automatic logic [MSHR_IDX_W-1:0] lowest_set(input logic [MSHR_NUM-1:0] vec);
        logic [MSHR_IDX_W-1:0] idx;
        idx = '0;
        for (int i = MSHR_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = MSHR_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // reserved entries are held back for static requests
    assign dyn_free    = ~valid_q & ~resv_q;
    assign static_free = ~valid_q & resv_q;

    assign alloc_idx    = is_static ? lowest_set(static_free) : lowest_set(dyn_free);
    assign retire_class = class_q[retire_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            resv_q  <= '0;
        end else begin
            if (retire_valid) begin
                valid_q[retire_idx] <= 1'b0;
                if (convert) begin
                    resv_q[retire_idx] <= 1'b1;
                end
            end
            if (alloc_en) begin
                valid_q[alloc_idx] <= 1'b1;
                if (is_static) begin
                    resv_q[alloc_idx] <= 1'b0;
                end
            end
        end
    end

    // static entries come in as CLASS_NONE
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            class_q[alloc_idx] <= use_class;
        end
    end

    a_retire_valid: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> valid_q[retire_idx]);

    a_static_resv: assert property (@(posedge clk) disable iff (rst)
        (alloc_en && is_static) |-> (|static_free));

endmodule

//--- hdl/retry_bank.sv
// ##########################################################################
// Retry bank of retried sources with high and low pending counts
// ##########################################################################
`timescale 1ns/100ps

module retry_bank
    import qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retry,
    input  logic                  is_high,
    input  logic [SRCID_W-1:0]    req_srcid,
    input  logic                  dec_high,
    input  logic                  dec_low,
    input  logic [BANK_IDX_W-1:0] dec_sel,
    output logic                  high_pend,
    output logic                  low_pend,
    output logic [BANK_IDX_W-1:0] high_sel,
    output logic [BANK_IDX_W-1:0] low_sel,
    output logic [SRCID_W-1:0]    high_srcid,
    output logic [SRCID_W-1:0]    low_srcid
);

    logic [BANK_NUM-1:0]   bank_v_q;
    logic [SRCID_W-1:0]    srcid_q [BANK_NUM];
    logic [BANK_CNT_W-1:0] hcnt_q [BANK_NUM];
    logic [BANK_CNT_W-1:0] lcnt_q [BANK_NUM];
    logic [BANK_IDX_W-1:0] ptr_q;
    logic [BANK_NUM-1:0]   match;
    logic [BANK_NUM-1:0]   inc_h;
    logic [BANK_NUM-1:0]   inc_l;
    logic [BANK_NUM-1:0]   dec_h;
    logic [BANK_NUM-1:0]   dec_l;
    logic [BANK_NUM-1:0]   hcand;
    logic [BANK_NUM-1:0]   lcand;
    logic                  new_src;

    function automatic logic [BANK_IDX_W-1:0] lowest_set(input logic [BANK_NUM-1:0] vec);
        logic [BANK_IDX_W-1:0] idx;
        idx = '0;
        for (int i = BANK_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = BANK_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < BANK_NUM; i++) begin
            match[i] = bank_v_q[i] & (srcid_q[i] == req_srcid);
            inc_h[i] = retry & is_high & match[i];
            inc_l[i] = retry & ~is_high & match[i];
            dec_h[i] = dec_high & (dec_sel == BANK_IDX_W'(i));
            dec_l[i] = dec_low & (dec_sel == BANK_IDX_W'(i));
            // an entry being decremented sits out this cycle
            hcand[i] = bank_v_q[i] & (hcnt_q[i] != '0) & ~dec_h[i];
            lcand[i] = bank_v_q[i] & (lcnt_q[i] != '0) & ~dec_l[i];
        end
    end

    assign new_src = retry & ~(|match);

    assign high_pend  = |hcand;
    assign low_pend   = |lcand;
    assign high_sel   = lowest_set(hcand);
    assign low_sel    = lowest_set(lcand);
    assign high_srcid = srcid_q[high_sel];
    assign low_srcid  = srcid_q[low_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_v_q <= '0;
            ptr_q    <= '0;
            for (int i = 0; i < BANK_NUM; i++) begin
                hcnt_q[i] <= '0;
                lcnt_q[i] <= '0;
            end
        end else begin
            if (new_src) begin
                bank_v_q[ptr_q] <= 1'b1;
                ptr_q           <= ptr_q + 1'b1;
            end
            for (int i = 0; i < BANK_NUM; i++) begin
                if (new_src && (ptr_q == BANK_IDX_W'(i))) begin
                    // overwriting the slot forgets the old source
                    hcnt_q[i] <= is_high ? BANK_CNT_W'(1) : '0;
                    lcnt_q[i] <= is_high ? '0 : BANK_CNT_W'(1);
                end else begin
                    if (inc_h[i] && !dec_h[i]) begin
                        hcnt_q[i] <= hcnt_q[i] + 1'b1;
                    end else if (!inc_h[i] && dec_h[i]) begin
                        hcnt_q[i] <= hcnt_q[i] - 1'b1;
                    end
                    if (inc_l[i] && !dec_l[i]) begin
                        lcnt_q[i] <= lcnt_q[i] + 1'b1;
                    end else if (!inc_l[i] && dec_l[i]) begin
                        lcnt_q[i] <= lcnt_q[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_src) begin
            srcid_q[ptr_q] <= req_srcid;
        end
    end

endmodule

//--- hdl/pcrd_arbiter.sv
// ##########################################################################
// Protocol-credit arbiter with the class winner at retire and a grant stage
// ##########################################################################
`timescale 1ns/100ps

module pcrd_arbiter
    import qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire_valid,
    input  qos_class_t            retire_class,
    input  logic                  high_pend,
    input  logic                  low_pend,
    input  logic [BANK_IDX_W-1:0] high_sel,
    input  logic [BANK_IDX_W-1:0] low_sel,
    input  logic [SRCID_W-1:0]    high_srcid,
    input  logic [SRCID_W-1:0]    low_srcid,
    input  logic                  gnt_full,
    input  logic                  grant_pop,
    output logic                  convert,
    output logic                  dec_high,
    output logic                  dec_low,
    output logic [BANK_IDX_W-1:0] dec_sel,
    output logic                  gnt_push,
    output grant_entry_t          gnt_data
);

    logic                  win_high;
    logic                  win_low;
    logic                  win_high_q;
    logic                  win_low_q;
    logic [BANK_IDX_W-1:0] sel_q;
    logic [SRCID_W-1:0]    srcid_q;

    // a high retry may take a low or high entry and a low retry only a low one
    assign win_high = retire_valid & high_pend &
                      ((retire_class == CLASS_LOW) | (retire_class == CLASS_HIGH));
    assign win_low  = retire_valid & low_pend & (retire_class == CLASS_LOW) & ~win_high;
    assign convert  = win_high | win_low;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_high_q <= 1'b0;
            win_low_q  <= 1'b0;
        end else begin
            win_high_q <= win_high;
            win_low_q  <= win_low;
        end
    end

    always_ff @(posedge clk) begin
        if (convert) begin
            sel_q   <= win_high ? high_sel : low_sel;
            srcid_q <= win_high ? high_srcid : low_srcid;
        end
    end

    // count drops only when the grant actually lands in the queue
    assign gnt_push = (win_high_q | win_low_q) & (~gnt_full | grant_pop);
    assign dec_high = win_high_q & gnt_push;
    assign dec_low  = win_low_q & gnt_push;
    assign dec_sel  = sel_q;

    assign gnt_data = '{
        srcid:    srcid_q,
        qos:      win_high_q ? GNT_QOS_HIGH : GNT_QOS_LOW,
        pcrdtype: win_high_q ? PCRD_HIGH : PCRD_LOW
    };

endmodule

//--- hdl/hni_qos_top.sv
// ##########################################################################
// HN-I QoS admission top with MSHR state, retry bank and credit grants
// ##########################################################################
`timescale 1ns/100ps

module hni_qos_top
    import qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [SRCID_W-1:0]    req_srcid,
    input  logic [TXNID_W-1:0]    req_txnid,
    input  logic [QOS_W-1:0]      req_qos,
    input  logic                  req_allowretry,
    input  logic                  retire_valid,
    input  logic [MSHR_IDX_W-1:0] retire_idx,
    input  logic                  ack_pop,
    input  logic                  grant_pop,
    output logic                  alloc_en,
    output logic [MSHR_IDX_W-1:0] alloc_idx,
    output logic                  retry,
    output logic                  ack_valid,
    output logic [SRCID_W-1:0]    ack_srcid,
    output logic [TXNID_W-1:0]    ack_txnid,
    output logic [QOS_W-1:0]      ack_qos,
    output logic [PCRDTYPE_W-1:0] ack_pcrdtype,
    output logic                  grant_valid,
    output logic [SRCID_W-1:0]    grant_srcid,
    output logic [QOS_W-1:0]      grant_qos,
    output logic [PCRDTYPE_W-1:0] grant_pcrdtype
);

    logic                  is_static;
    qos_class_t            use_class;
    qos_class_t            retire_class;
    logic                  convert;
    logic                  is_high;
    ack_entry_t            ack_data;
    ack_entry_t            ack_rd;
    logic                  ack_empty;
    logic                  high_pend;
    logic                  low_pend;
    logic [BANK_IDX_W-1:0] high_sel;
    logic [BANK_IDX_W-1:0] low_sel;
    logic [SRCID_W-1:0]    high_srcid;
    logic [SRCID_W-1:0]    low_srcid;
    logic                  dec_high;
    logic                  dec_low;
    logic [BANK_IDX_W-1:0] dec_sel;
    logic                  gnt_push;
    grant_entry_t          gnt_data;
    grant_entry_t          gnt_rd;
    logic                  gnt_empty;
    logic                  gnt_full;

    pool_admit u_pool_admit (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_srcid      (req_srcid),
        .req_txnid      (req_txnid),
        .req_qos        (req_qos),
        .req_allowretry (req_allowretry),
        .retire_valid   (retire_valid),
        .retire_class   (retire_class),
        .convert        (convert),
        .alloc_en       (alloc_en),
        .is_static      (is_static),
        .use_class      (use_class),
        .retry          (retry),
        .is_high        (is_high),
        .ack_data       (ack_data)
    );

    mshr_tracker u_mshr_tracker (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .is_static    (is_static),
        .use_class    (use_class),
        .retire_valid (retire_valid),
        .retire_idx   (retire_idx),
        .convert      (convert),
        .alloc_idx    (alloc_idx),
        .retire_class (retire_class)
    );

    retry_bank u_retry_bank (
        .clk        (clk),
        .rst        (rst),
        .retry      (retry),
        .is_high    (is_high),
        .req_srcid  (req_srcid),
        .dec_high   (dec_high),
        .dec_low    (dec_low),
        .dec_sel    (dec_sel),
        .high_pend  (high_pend),
        .low_pend   (low_pend),
        .high_sel   (high_sel),
        .low_sel    (low_sel),
        .high_srcid (high_srcid),
        .low_srcid  (low_srcid)
    );

    pcrd_arbiter u_pcrd_arbiter (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_class (retire_class),
        .high_pend    (high_pend),
        .low_pend     (low_pend),
        .high_sel     (high_sel),
        .low_sel      (low_sel),
        .high_srcid   (high_srcid),
        .low_srcid    (low_srcid),
        .gnt_full     (gnt_full),
        .grant_pop    (grant_pop),
        .convert      (convert),
        .dec_high     (dec_high),
        .dec_low      (dec_low),
        .dec_sel      (dec_sel),
        .gnt_push     (gnt_push),
        .gnt_data     (gnt_data)
    );

    resp_fifo #(.entry_t(ack_entry_t), .DEPTH(ACKQ_DEPTH)) u_ack_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (retry),
        .pop     (ack_pop),
        .wr_data (ack_data),
        .rd_data (ack_rd),
        .empty   (ack_empty),
        .full    ()
    );

    resp_fifo #(.entry_t(grant_entry_t), .DEPTH(GNTQ_DEPTH)) u_gnt_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (gnt_push),
        .pop     (grant_pop),
        .wr_data (gnt_data),
        .rd_data (gnt_rd),
        .empty   (gnt_empty),
        .full    (gnt_full)
    );

    assign ack_valid      = ~ack_empty;
    assign ack_srcid      = ack_rd.srcid;
    assign ack_txnid      = ack_rd.txnid;
    assign ack_qos        = ack_rd.qos;
    assign ack_pcrdtype   = ack_rd.pcrdtype;
    assign grant_valid    = ~gnt_empty;
    assign grant_srcid    = gnt_rd.srcid;
    assign grant_qos      = gnt_rd.qos;
    assign grant_pcrdtype = gnt_rd.pcrdtype;

endmodule

//--- tests/tb_hni_qos.sv
// ##########################################################################
// Table-driven testbench for the HN-I QoS admission block with queue models
// ##########################################################################
`timescale 1ns/100ps

module tb_hni_qos
    import qos_pkg::*;
();

    localparam int ROWS = 22;

    typedef struct {
        logic                  rv;
        logic [SRCID_W-1:0]    src;
        logic [TXNID_W-1:0]    txn;
        logic [QOS_W-1:0]      qos;
        logic                  ar;
        logic                  tv;
        logic [MSHR_IDX_W-1:0] tidx;
        logic                  apop;
        logic                  gpop;
        logic                  e_en;
        logic [MSHR_IDX_W-1:0] e_idx;
        logic                  e_retry;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic [SRCID_W-1:0]    req_srcid;
    logic [TXNID_W-1:0]    req_txnid;
    logic [QOS_W-1:0]      req_qos;
    logic                  req_allowretry;
    logic                  retire_valid;
    logic [MSHR_IDX_W-1:0] retire_idx;
    logic                  ack_pop;
    logic                  grant_pop;
    logic                  alloc_en;
    logic [MSHR_IDX_W-1:0] alloc_idx;
    logic                  retry;
    logic                  ack_valid;
    logic [SRCID_W-1:0]    ack_srcid;
    logic [TXNID_W-1:0]    ack_txnid;
    logic [QOS_W-1:0]      ack_qos;
    logic [PCRDTYPE_W-1:0] ack_pcrdtype;
    logic                  grant_valid;
    logic [SRCID_W-1:0]    grant_srcid;
    logic [QOS_W-1:0]      grant_qos;
    logic [PCRDTYPE_W-1:0] grant_pcrdtype;

    row_t rows [ROWS];
    int   n_rows;
    int   val_errs;
    int   other_errs;

    // reference model of pools, entry classes, retry bank and grant stage
    int                 hp_cnt;
    int                 lp_cnt;
    int                 ent_cls [MSHR_NUM];
    logic               b_v [BANK_NUM];
    int                 b_src [BANK_NUM];
    int                 b_hc [BANK_NUM];
    int                 b_lc [BANK_NUM];
    int                 b_ptr;
    logic               stg_h;
    logic               stg_l;
    int                 stg_sel;
    logic [SRCID_W-1:0] stg_src;
    ack_entry_t         ackq [$];
    grant_entry_t       gntq [$];

    hni_qos_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_srcid      (req_srcid),
        .req_txnid      (req_txnid),
        .req_qos        (req_qos),
        .req_allowretry (req_allowretry),
        .retire_valid   (retire_valid),
        .retire_idx     (retire_idx),
        .ack_pop        (ack_pop),
        .grant_pop      (grant_pop),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .retry          (retry),
        .ack_valid      (ack_valid),
        .ack_srcid      (ack_srcid),
        .ack_txnid      (ack_txnid),
        .ack_qos        (ack_qos),
        .ack_pcrdtype   (ack_pcrdtype),
        .grant_valid    (grant_valid),
        .grant_srcid    (grant_srcid),
        .grant_qos      (grant_qos),
        .grant_pcrdtype (grant_pcrdtype)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((ROWS + 20) * 4);
        $display("watchdog expired before the stimulus table finished");
        $display("Something failed");
        $finish;
    end

    task automatic add_row(input logic rv, input int src, input int txn, input int qos,
                           input logic ar, input logic tv, input int tidx, input logic apop,
                           input logic gpop, input logic e_en, input int e_idx,
                           input logic e_retry);
        rows[n_rows].rv      = rv;
        rows[n_rows].src     = src;
        rows[n_rows].txn     = txn;
        rows[n_rows].qos     = qos;
        rows[n_rows].ar      = ar;
        rows[n_rows].tv      = tv;
        rows[n_rows].tidx    = tidx;
        rows[n_rows].apop    = apop;
        rows[n_rows].gpop    = gpop;
        rows[n_rows].e_en    = e_en;
        rows[n_rows].e_idx   = e_idx;
        rows[n_rows].e_retry = e_retry;
        n_rows++;
    endtask

    task automatic fill_table();
        n_rows = 0;
        // rv src txn qos ar | tv tidx | apop gpop | en idx retry
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 1, 'h10, 12, 1, 0, 0, 0, 0, 1, 0, 0);
        add_row(1, 1, 'h11,  9, 1, 0, 0, 0, 0, 1, 1, 0);
        // high pool full so this one overflows to low
        add_row(1, 2, 'h12, 15, 1, 0, 0, 0, 0, 1, 2, 0);
        add_row(1, 3, 'h13,  2, 1, 0, 0, 0, 0, 1, 3, 0);
        add_row(1, 3, 'h14,  0, 1, 0, 0, 0, 0, 1, 4, 0);
        add_row(1, 4, 'h15,  7, 1, 0, 0, 0, 0, 1, 5, 0);
        add_row(1, 5, 'h16,  3, 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(1, 6, 'h17, 10, 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 1, 0, 0, 0, 0);
        // low class entry retires and the high source gets the credit
        add_row(0, 0, 'h00,  0, 1, 1, 2, 1, 0, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 1, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 1, 3, 0, 0, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 1, 0, 0, 0);
        // static request lands on the reserved entry
        add_row(1, 7, 'h20,  4, 0, 0, 0, 0, 0, 1, 2, 0);
        add_row(0, 0, 'h00,  0, 1, 1, 0, 0, 0, 0, 0, 0);
        add_row(1, 8, 'h21,  8, 1, 0, 0, 0, 0, 1, 0, 0);
        add_row(1, 9, 'h22,  1, 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 1, 0, 0, 0, 0);
        add_row(0, 0, 'h00,  0, 1, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic apply_row(input int r);
        req_valid      = rows[r].rv;
        req_srcid      = rows[r].src;
        req_txnid      = rows[r].txn;
        req_qos        = rows[r].qos;
        req_allowretry = rows[r].ar;
        retire_valid   = rows[r].tv;
        retire_idx     = rows[r].tidx;
        ack_pop        = rows[r].apop;
        grant_pop      = rows[r].gpop;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int r);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h exp 0x%0h (row %0d)", name, got, exp, r);
            val_errs++;
        end
    endtask

    task automatic check_outputs(input int r);
        check_value("alloc_en", alloc_en, rows[r].e_en, r);
        if (rows[r].e_en) begin
            check_value("alloc_idx", alloc_idx, rows[r].e_idx, r);
        end
        check_value("retry", retry, rows[r].e_retry, r);
        check_value("ack_valid", ack_valid, ackq.size() != 0, r);
        check_value("grant_valid", grant_valid, gntq.size() != 0, r);
        if (rows[r].apop && ackq.size() == 0) begin
            $display("row %0d pops the ack queue while no retry ack is expected", r);
            other_errs++;
        end else if (rows[r].apop) begin
            check_value("ack_srcid", ack_srcid, ackq[0].srcid, r);
            check_value("ack_txnid", ack_txnid, ackq[0].txnid, r);
            check_value("ack_qos", ack_qos, ackq[0].qos, r);
            check_value("ack_pcrdtype", ack_pcrdtype, ackq[0].pcrdtype, r);
        end
        if (rows[r].gpop && gntq.size() == 0) begin
            $display("row %0d pops the grant queue while no grant is expected", r);
            other_errs++;
        end else if (rows[r].gpop) begin
            check_value("grant_srcid", grant_srcid, gntq[0].srcid, r);
            check_value("grant_qos", grant_qos, gntq[0].qos, r);
            check_value("grant_pcrdtype", grant_pcrdtype, gntq[0].pcrdtype, r);
        end
    endtask

    task automatic update_model(input int r);
        logic         was_full;
        logic         dec_hit;
        logic         win_h;
        logic         win_l;
        logic         is_hi;
        logic         use_h;
        logic         use_l;
        int           dsel;
        int           hsel;
        int           lsel;
        int           cls;
        int           found;
        ack_entry_t   ack_e;
        grant_entry_t gnt_e;
        was_full = (gntq.size() == GNTQ_DEPTH);
        if (rows[r].apop && ackq.size() != 0) void'(ackq.pop_front());
        if (rows[r].gpop && gntq.size() != 0) void'(gntq.pop_front());
        // grant from last cycle's retire lands unless the queue stays full
        dec_hit = 1'b0;
        dsel    = -1;
        if ((stg_h || stg_l) && (!was_full || rows[r].gpop)) begin
            gnt_e.srcid    = stg_src;
            gnt_e.qos      = stg_h ? 4'hf : 4'h0;
            gnt_e.pcrdtype = stg_h ? 4'd2 : 4'd1;
            gntq.push_back(gnt_e);
            dec_hit = 1'b1;
            dsel    = stg_sel;
        end
        hsel = -1;
        lsel = -1;
        for (int i = BANK_NUM - 1; i >= 0; i--) begin
            if (b_v[i] && b_hc[i] != 0 && !(dec_hit && stg_h && i == dsel)) hsel = i;
            if (b_v[i] && b_lc[i] != 0 && !(dec_hit && stg_l && i == dsel)) lsel = i;
        end
        cls   = ent_cls[rows[r].tidx];
        win_h = rows[r].tv && hsel >= 0 && (cls == 1 || cls == 2);
        win_l = rows[r].tv && lsel >= 0 && cls == 1 && !win_h;
        if (dec_hit && stg_h) b_hc[dsel]--;
        if (dec_hit && stg_l) b_lc[dsel]--;
        stg_h = win_h;
        stg_l = win_l;
        stg_sel = win_h ? hsel : lsel;
        if (win_h || win_l) stg_src = b_src[stg_sel];
        // admission against the pool counts of this cycle
        is_hi = (rows[r].qos >= QOS_HIGH_MIN);
        use_h = rows[r].rv && rows[r].ar && is_hi && hp_cnt < HIGH_POOL_NUM;
        use_l = rows[r].rv && rows[r].ar && !use_h && lp_cnt < LOW_POOL_NUM;
        if (rows[r].rv && !rows[r].ar) begin
            ent_cls[rows[r].e_idx] = 0;
        end else if (use_h) begin
            ent_cls[rows[r].e_idx] = 2;
            hp_cnt++;
        end else if (use_l) begin
            ent_cls[rows[r].e_idx] = 1;
            lp_cnt++;
        end else if (rows[r].rv) begin
            ack_e.srcid    = rows[r].src;
            ack_e.txnid    = rows[r].txn;
            ack_e.qos      = rows[r].qos;
            ack_e.pcrdtype = is_hi ? 4'd2 : 4'd1;
            ackq.push_back(ack_e);
            found = -1;
            for (int i = 0; i < BANK_NUM; i++) begin
                if (b_v[i] && b_src[i] == rows[r].src) found = i;
            end
            if (found >= 0 && is_hi) b_hc[found]++;
            if (found >= 0 && !is_hi) b_lc[found]++;
            if (found < 0) begin
                b_v[b_ptr]   = 1'b1;
                b_src[b_ptr] = rows[r].src;
                b_hc[b_ptr]  = is_hi ? 1 : 0;
                b_lc[b_ptr]  = is_hi ? 0 : 1;
                b_ptr        = (b_ptr + 1) % BANK_NUM;
            end
        end
        // converted entries keep their pool slot
        if (rows[r].tv && !win_h && !win_l && cls == 2) hp_cnt--;
        if (rows[r].tv && !win_h && !win_l && cls == 1) lp_cnt--;
    endtask

    initial begin
        rst        = 1'b1;
        val_errs   = 0;
        other_errs = 0;
        hp_cnt     = 0;
        lp_cnt     = 0;
        b_ptr      = 0;
        stg_h      = 1'b0;
        stg_l      = 1'b0;
        stg_sel    = 0;
        stg_src    = '0;
        for (int i = 0; i < MSHR_NUM; i++) ent_cls[i] = 0;
        for (int i = 0; i < BANK_NUM; i++) begin
            b_v[i]   = 1'b0;
            b_src[i] = 0;
            b_hc[i]  = 0;
            b_lc[i]  = 0;
        end
        fill_table();
        apply_row(0);
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #1;
            apply_row(r);
            #2;
            check_outputs(r);
            update_model(r);
        end
        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/qos_pkg.sv
hdl/resp_fifo.sv
hdl/pool_admit.sv
hdl/mshr_tracker.sv
hdl/retry_bank.sv
hdl/pcrd_arbiter.sv
hdl/hni_qos_top.sv
tests/tb_hni_qos.sv
